//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fpconv_tb
FILELIST  = project.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- design/fp32_to_fp64.sv
/*
 * Single to double widening converter
 * Always exact, subnormal singles come out as normal doubles
 */
`timescale 1ns/10ps
`include "fpconv_consts.svh"

module fp32_to_fp64 (
    input  logic [31:0]           fp32_in,
    output logic [63:0]           fp64_out,
    output fpconv_pkg::fp_flags_t flags
);

    logic        sign;
    logic [7:0]  exp_in;
    logic [22:0] frac_in;
    logic [4:0]  norm_shift;
    logic [23:0] norm_frac;

    assign sign    = fp32_in[31];
    assign exp_in  = fp32_in[30:23];
    assign frac_in = fp32_in[22:0];

    // Shift that moves the leading one out of the fraction field
    always_comb begin
        norm_shift = 5'd0;
        for (int i = 0; i < 23; i++) begin
            if (frac_in[i]) begin
                norm_shift = 5'(23 - i);
            end
        end
    end

    assign norm_frac = {1'b0, frac_in} << norm_shift;

    // ============================================================
    // Result select
    // ============================================================
    always_comb begin
        flags = '0;
        if (exp_in == 8'hFF) begin
            if (frac_in == 23'd0) begin
                fp64_out = {sign, 11'h7FF, 52'd0};
            end else begin
                // Left-align payload, quiet bit set
                fp64_out      = {sign, 11'h7FF, 1'b1, frac_in[21:0], 29'd0};
                flags.invalid = !frac_in[22];
            end
        end else if (exp_in == 8'd0) begin
            if (frac_in == 23'd0) begin
                fp64_out = {sign, 63'd0};
            end else begin
                // Subnormal single, normalize
                fp64_out = {sign, 11'(`FPCONV_BIAS_DIFF + 1 - norm_shift),
                            norm_frac[22:0], 29'd0};
            end
        end else begin
            fp64_out = {sign, 11'({3'b000, exp_in} + `FPCONV_BIAS_DIFF), frac_in, 29'd0};
        end
    end

endmodule

//--- design/fp64_classify.sv
/*
 * Double-precision classifier
 * Sorts an IEEE 754 double into one of ten classes
 */
`timescale 1ns/10ps

module fp64_classify (
    input  logic [63:0]           in,
    output fpconv_pkg::fp_class_e fp_class
);

    logic        sign;
    logic [10:0] exp_f;
    logic [51:0] frac_f;

    assign sign   = in[63];
    assign exp_f  = in[62:52];
    assign frac_f = in[51:0];

    always_comb begin
        if (exp_f == 11'h7FF) begin
            // All-ones exponent, infinity or NaN
            if (frac_f == 52'd0) begin
                fp_class = sign ? fpconv_pkg::neg_inf : fpconv_pkg::pos_inf;
            end else if (frac_f[51]) begin
                // Quiet bit set
                fp_class = fpconv_pkg::qnan;
            end else begin
                fp_class = fpconv_pkg::snan;
            end
        end else if (exp_f == 11'd0) begin
            // Zero exponent, zero or subnormal
            if (frac_f == 52'd0) begin
                fp_class = sign ? fpconv_pkg::neg_zero : fpconv_pkg::pos_zero;
            end else begin
                fp_class = sign ? fpconv_pkg::neg_denorm : fpconv_pkg::pos_denorm;
            end
        end else begin
            fp_class = sign ? fpconv_pkg::neg_norm : fpconv_pkg::pos_norm;
        end
    end

endmodule

//--- design/fp64_to_fp32.sv
/*
 * Double to single narrowing converter
 * Truncates toward zero, saturates to infinity on overflow,
 * produces subnormals or signed zero on underflow, raises IEEE flags
 */
`timescale 1ns/10ps
`include "fpconv_consts.svh"

module fp64_to_fp32 (
    input  logic [63:0]           fp64_in,
    input  fpconv_pkg::fp_class_e fp_class,
    output logic [31:0]           fp32_out,
    output fpconv_pkg::fp_flags_t flags
);

    logic               sign;
    logic [10:0]        exp_in;
    logic [51:0]        frac_in;
    logic signed [12:0] exp_rb;
    logic [52:0]        full_mant;
    logic [5:0]         dn_shift;
    logic [52:0]        dn_shifted;

    assign sign    = fp64_in[63];
    assign exp_in  = fp64_in[62:52];
    assign frac_in = fp64_in[51:0];

    // Rebias from double to single
    assign exp_rb    = 13'($signed({2'b00, exp_in}) - `FPCONV_BIAS_DIFF);
    assign full_mant = {1'b1, frac_in};

    // Subnormal alignment, only meaningful for exp_rb in -22..0
    assign dn_shift   = 6'(13'sd30 - exp_rb);
    assign dn_shifted = full_mant >> dn_shift;

    // ============================================================
    // Result select
    // ============================================================
    always_comb begin
        fp32_out = 32'd0;
        flags    = '0;
        case (fp_class)
            fpconv_pkg::snan, fpconv_pkg::qnan: begin
                // Keep payload prefix, force quiet
                fp32_out      = {sign, 8'hFF, 1'b1, frac_in[50:29]};
                flags.invalid = (fp_class == fpconv_pkg::snan);
            end
            fpconv_pkg::neg_inf, fpconv_pkg::pos_inf: begin
                fp32_out = {sign, 8'hFF, 23'd0};
            end
            fpconv_pkg::neg_zero, fpconv_pkg::pos_zero: begin
                fp32_out = {sign, 31'd0};
            end
            fpconv_pkg::neg_denorm, fpconv_pkg::pos_denorm: begin
                // Far below single range
                fp32_out        = {sign, 31'd0};
                flags.underflow = 1'b1;
                flags.inexact   = 1'b1;
            end
            default: begin
                if (exp_rb > 13'sd254) begin
                    fp32_out       = {sign, 8'hFF, 23'd0};
                    flags.overflow = 1'b1;
                    flags.inexact  = 1'b1;
                end else if (exp_rb < -13'sd22) begin
                    fp32_out        = {sign, 31'd0};
                    flags.underflow = 1'b1;
                    flags.inexact   = 1'b1;
                end else if (exp_rb < 13'sd1) begin
                    // Subnormal single
                    fp32_out        = {sign, 8'd0, dn_shifted[22:0]};
                    flags.underflow = 1'b1;
                    flags.inexact   = ((dn_shifted << dn_shift) != full_mant);
                end else begin
                    // Truncate the low 29 bits
                    fp32_out      = {sign, exp_rb[7:0], frac_in[51:29]};
                    flags.inexact = (frac_in[28:0] != 29'd0);
                end
            end
        endcase
    end

    // Classifier and this datapath must agree on NaN encodings
    always_comb begin
        assert final (!(fp_class inside {fpconv_pkg::snan, fpconv_pkg::qnan}) ||
                      exp_in == 11'h7FF)
            else $error("NaN class with exponent %h", exp_in);
    end

endmodule

//--- design/fpconv_apb.sv
/*
 * APB3 register block for the conversion unit
 * Operand and control registers, launch pulse, result readback,
 * error response for unmapped offsets
 */
`timescale 1ns/10ps
`include "fpconv_consts.svh"

module fpconv_apb (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    fpconv_if.regs      bus
);

    // APB phase seen in the previous cycle
    typedef enum logic [1:0] {
        idle,
        setup,
        access
    } apb_state_e;

    apb_state_e           apb_state;
    apb_state_e           apb_next;
    logic [31:0]          oplo;
    logic [31:0]          ophi;
    fpconv_pkg::conv_op_e op_q;
    logic                 start_q;
    logic                 access_en;
    logic                 wr_en;
    logic                 addr_hit;
    logic [31:0]          rdata_mux;

    // ============================================================
    // Phase tracking
    // ============================================================
    always_comb begin
        if (!psel) begin
            apb_next = idle;
        end else if (!penable) begin
            apb_next = setup;
        end else begin
            apb_next = access;
        end
    end

    // Zero wait states
    assign pready    = 1'b1;
    // Access counts only right after a setup cycle
    assign access_en = psel & penable & pready & (apb_state == setup);
    assign wr_en     = access_en & pwrite;

    // ============================================================
    // Register writes and launch
    // ============================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            apb_state <= idle;
            oplo      <= 32'd0;
            ophi      <= 32'd0;
            op_q      <= fpconv_pkg::op_f64_to_f32;
            start_q   <= 1'b0;
        end else begin
            apb_state <= apb_next;
            start_q   <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    `FPCONV_ADDR_OPLO: oplo <= pwdata;
                    `FPCONV_ADDR_OPHI: ophi <= pwdata;
                    `FPCONV_ADDR_CTRL: begin
                        op_q    <= fpconv_pkg::conv_op_e'(pwdata[`FPCONV_CTRL_OP]);
                        start_q <= pwdata[`FPCONV_CTRL_START];
                    end
                    // Status and result offsets are read only
                    default: ;
                endcase
            end
        end
    end

    assign bus.operand = {ophi, oplo};
    assign bus.op      = op_q;
    assign bus.start   = start_q;

    // ============================================================
    // Read mux and decode error
    // ============================================================
    always_comb begin
        rdata_mux = 32'd0;
        addr_hit  = 1'b1;
        case (paddr)
            `FPCONV_ADDR_OPLO:  rdata_mux = oplo;
            `FPCONV_ADDR_OPHI:  rdata_mux = ophi;
            `FPCONV_ADDR_CTRL:  rdata_mux[`FPCONV_CTRL_OP] = op_q;
            `FPCONV_ADDR_STATUS: begin
                rdata_mux[`FPCONV_STATUS_DONE]           = bus.done;
                rdata_mux[`FPCONV_STATUS_FLAGS_LSB +: 4] = bus.flags;
            end
            `FPCONV_ADDR_RESLO: rdata_mux = bus.result[31:0];
            `FPCONV_ADDR_RESHI: rdata_mux = bus.result[63:32];
            default:            addr_hit = 1'b0;
        endcase
    end

    assign prdata  = (access_en && !pwrite && addr_hit) ? rdata_mux : 32'd0;
    assign pslverr = access_en & ~addr_hit;

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> psel);

    a_start_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        start_q |=> !start_q);

endmodule

//--- design/fpconv_consts.svh
/*
 * Floating-point conversion unit constants
 * APB register offsets, control and status bit positions,
 * IEEE 754 exponent biases
 */
`ifndef FPCONV_CONSTS_SVH
`define FPCONV_CONSTS_SVH

// APB register offsets
`define FPCONV_ADDR_OPLO        8'h00
`define FPCONV_ADDR_OPHI        8'h04
`define FPCONV_ADDR_CTRL        8'h08
`define FPCONV_ADDR_STATUS      8'h0C
`define FPCONV_ADDR_RESLO       8'h10
`define FPCONV_ADDR_RESHI       8'h14

// Control word bits
`define FPCONV_CTRL_START       0
`define FPCONV_CTRL_OP          1

// Status word, flags sit in bits 4:1
`define FPCONV_STATUS_DONE      0
`define FPCONV_STATUS_FLAGS_LSB 1

// Exponent biases
`define FP64_BIAS               1023
`define FP32_BIAS               127
`define FPCONV_BIAS_DIFF        (`FP64_BIAS - `FP32_BIAS)

`endif

//--- design/fpconv_core.sv
/*
 * Conversion core
 * Both converters run on the operand, the opcode picks one,
 * and the result and flags are captured on start
 */
`timescale 1ns/10ps

module fpconv_core (
    input  logic   clk,
    input  logic   rst_n,
    fpconv_if.core bus
);

    fpconv_pkg::fp_class_e op_class;
    logic [31:0]           narrow_res;
    fpconv_pkg::fp_flags_t narrow_flags;
    logic [63:0]           wide_res;
    fpconv_pkg::fp_flags_t wide_flags;
    logic                  done_q;

    fp64_classify u_classify (.in(bus.operand), .fp_class(op_class));

    fp64_to_fp32 u_narrow (
        .fp64_in (bus.operand),
        .fp_class(op_class),
        .fp32_out(narrow_res),
        .flags   (narrow_flags)
    );

    // Single operand lives in the low word
    fp32_to_fp64 u_widen (.fp32_in(bus.operand[31:0]), .fp64_out(wide_res), .flags(wide_flags));

    // Capture on start, hold otherwise
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus.result <= 64'd0;
            bus.flags  <= '0;
            done_q     <= 1'b0;
        end else if (bus.start) begin
            if (bus.op == fpconv_pkg::op_f64_to_f32) begin
                bus.result <= {32'd0, narrow_res};
                bus.flags  <= narrow_flags;
            end else begin
                bus.result <= wide_res;
                bus.flags  <= wide_flags;
            end
            done_q <= 1'b1;
        end
    end

    // Old done hidden while a launch is in progress
    assign bus.done = done_q & ~bus.start;

    // Launch pulse ends and done shows up on the next cycle
    a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        bus.start |=> bus.done);

endmodule

//--- design/fpconv_if.sv
/*
 * Register block to conversion core link
 * Operand, opcode and launch pulse go down, result and status come back
 */
`timescale 1ns/10ps

interface fpconv_if;

    // Launch side
    logic [63:0]          operand;
    fpconv_pkg::conv_op_e op;
    logic                 start;

    // Result side
    logic [63:0]          result;
    fpconv_pkg::fp_flags_t flags;
    logic                 done;

    modport regs (output operand, output op, output start,
                  input result, input flags, input done);

    modport core (input operand, input op, input start,
                  output result, output flags, output done);

endinterface

//--- design/fpconv_pkg.sv
/*
 * Floating-point conversion unit types
 * Double classes, conversion opcodes and exception flags
 */
package fpconv_pkg;

    // Class of a double-precision operand
    typedef enum logic [3:0] {
        snan,
        qnan,
        neg_inf,
        pos_inf,
        neg_norm,
        pos_norm,
        neg_denorm,
        pos_denorm,
        neg_zero,
        pos_zero
    } fp_class_e;

    // Conversion direction, matches the CTRL op bit
    typedef enum logic {
        op_f64_to_f32 = 1'b0,
        op_f32_to_f64 = 1'b1
    } conv_op_e;

    // Exception flags, MSB first in status order
    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

endpackage

//--- design/fpconv_top.sv
/*
 * Floating-point format conversion unit
 * APB3 slave around a double/single converter pair
 */
`timescale 1ns/10ps

module fpconv_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    // Register block to core link
    fpconv_if bus ();

    fpconv_apb u_apb (
        .clk    (clk),
        .rst_n  (rst_n),
        .paddr  (paddr),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr),
        .bus    (bus.regs)
    );

    fpconv_core u_core (
        .clk  (clk),
        .rst_n(rst_n),
        .bus  (bus.core)
    );

endmodule

//--- project.f
+incdir+design
design/fpconv_pkg.sv
design/fpconv_if.sv
design/fp64_classify.sv
design/fp64_to_fp32.sv
design/fp32_to_fp64.sv
design/fpconv_core.sv
design/fpconv_apb.sv
design/fpconv_top.sv
tb/fpconv_tb.sv

//--- tb/fpconv_cases.txt
// Columns: opcode (0 narrow, 1 widen) _ operand _ expected result _ flags
// Flags nibble is invalid, overflow, underflow, inexact from MSB down
0_3FF0000000000000_000000003F800000_0
0_C004000000000000_00000000C0200000_0
0_3FB999999999999A_000000003DCCCCCC_1
0_400921FB54442D18_0000000040490FDA_1
0_BFD5555555555555_00000000BEAAAAAA_1
0_47F0000000000000_000000007F800000_5
0_C7F0000000000000_00000000FF800000_5
0_47EFFFFFE0000000_000000007F7FFFFF_0
0_3800000000000000_0000000000400000_2
0_36A8000000000000_0000000000000001_3
0_B6A8000000000000_0000000080000001_3
0_3690000000000000_0000000000000000_3
0_0000000000000001_0000000000000000_3
0_8000000000000001_0000000080000000_3
0_7FF8000000000000_000000007FC00000_0
0_FFF8000020000000_00000000FFC00001_0
0_7FF4000000000000_000000007FE00000_8
0_7FF0000000000000_000000007F800000_0
0_FFF0000000000000_00000000FF800000_0
0_0000000000000000_0000000000000000_0
0_8000000000000000_0000000080000000_0
1_000000003F800000_3FF0000000000000_0
1_000000007F7FFFFF_47EFFFFFE0000000_0
1_0000000000000001_36A0000000000000_0
1_0000000000400000_3800000000000000_0
1_00000000807FFFFF_B80FFFFFC0000000_0
1_0000000000000003_36B8000000000000_0
1_00000000C2F6E979_C05EDD2F20000000_0
1_000000007FC00000_7FF8000000000000_0
1_000000007F800001_7FF8000020000000_8
1_00000000FFA00000_FFFC000000000000_8
1_000000007F800000_7FF0000000000000_0
1_00000000FF800000_FFF0000000000000_0
1_0000000000000000_0000000000000000_0
1_0000000080000000_8000000000000000_0

//--- tb/fpconv_tb.sv
/*
 * Testbench for the floating-point conversion unit
 * Loads conversion cases, runs them over APB, checks result, flags,
 * done and the slave error response
 */
`timescale 1ns/10ps
`include "fpconv_consts.svh"

module fpconv_tb;

    localparam int MAX_CASES = 64;

    logic        clk;
    logic        rst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    // Case word: opcode[135:132], operand[131:68], result[67:4], flags[3:0]
    logic [135:0] case_mem [0:MAX_CASES-1];
    int           num_cases;
    int           cycle_count;
    int           timeout_limit;
    int           error_count;
    int           check_count;
    logic [31:0]  lcg_state;

    fpconv_top uut (
        .clk    (clk),
        .rst_n  (rst_n),
        .paddr  (paddr),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // Run limit, cases times 40 cycles plus setup margin
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 to 3 idle cycles between transactions
    task automatic idle_gap();
        lcg_state = lcg_step(lcg_state);
        repeat (lcg_state[17:16]) @(posedge clk);
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        // Slave has no wait states
        @(negedge clk);
        check_ready(1'b1, pready);
        // Write lands on this edge
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic slverr);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        // Mid access phase, read data settled
        @(negedge clk);
        data   = prdata;
        slverr = pslverr;
        check_ready(1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_result(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: time %0t, %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_flags(input fpconv_pkg::fp_flags_t expected,
                               input fpconv_pkg::fp_flags_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: time %0t, flags expected %b actual %b",
                     $time, expected, actual);
        end
    endtask

    task automatic check_done(input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: time %0t, done expected %b actual %b", $time, expected, actual);
        end
    endtask

    task automatic check_slverr(input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: time %0t, pslverr expected %b actual %b",
                     $time, expected, actual);
        end
    endtask

    task automatic check_ready(input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error: time %0t, pready expected %b actual %b",
                     $time, expected, actual);
        end
    endtask

    // Read of a mapped register, never an error response
    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic slverr;
        apb_read(addr, data, slverr);
        check_slverr(1'b0, slverr);
    endtask

    // Load operand, launch, then read status and result
    task automatic run_case(input int idx);
        logic [63:0]           operand;
        logic [63:0]           exp_result;
        fpconv_pkg::fp_flags_t exp_flags;
        logic [31:0]           ctrl;
        logic [31:0]           status;
        logic [31:0]           res_lo;
        logic [31:0]           res_hi;
        operand    = case_mem[idx][131:68];
        exp_result = case_mem[idx][67:4];
        exp_flags  = fpconv_pkg::fp_flags_t'(case_mem[idx][3:0]);
        ctrl       = 32'd0;
        ctrl[`FPCONV_CTRL_OP]    = case_mem[idx][132];
        ctrl[`FPCONV_CTRL_START] = 1'b1;
        apb_write(`FPCONV_ADDR_OPLO, operand[31:0]);
        idle_gap();
        apb_write(`FPCONV_ADDR_OPHI, operand[63:32]);
        idle_gap();
        apb_write(`FPCONV_ADDR_CTRL, ctrl);
        idle_gap();
        // First status read after launch already sees done
        read_reg(`FPCONV_ADDR_STATUS, status);
        check_done(1'b1, status[`FPCONV_STATUS_DONE]);
        check_flags(exp_flags,
                    fpconv_pkg::fp_flags_t'(status[`FPCONV_STATUS_FLAGS_LSB +: 4]));
        idle_gap();
        read_reg(`FPCONV_ADDR_RESLO, res_lo);
        idle_gap();
        read_reg(`FPCONV_ADDR_RESHI, res_hi);
        idle_gap();
        check_result("result", exp_result, {res_hi, res_lo});
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        logic [31:0] status;
        logic [31:0] res_lo;
        logic [31:0] res_hi;
        logic [31:0] rdata;
        logic        slverr;
        logic [31:0] ctrl;
        clk         = 1'b0;
        rst_n       = 1'b0;
        paddr       = 8'd0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = 32'd0;
        cycle_count = 0;
        error_count = 0;
        check_count = 0;
        lcg_state   = 32'd41;

        // Opcode nibble F marks slots the file leaves empty
        for (int i = 0; i < MAX_CASES; i++) begin
            case_mem[i] = {4'hF, 132'(i)};
        end
        $readmemh("tb/fpconv_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases][135:132] < 4'd2) begin
            num_cases++;
        end
        if (num_cases == 0) begin
            $display("no test cases were loaded from tb/fpconv_cases.txt");
            error_count++;
        end
        timeout_limit = num_cases * 40 + 200;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // Nothing launched yet
        read_reg(`FPCONV_ADDR_STATUS, status);
        check_done(1'b0, status[`FPCONV_STATUS_DONE]);
        check_flags(fpconv_pkg::fp_flags_t'(4'h0),
                    fpconv_pkg::fp_flags_t'(status[`FPCONV_STATUS_FLAGS_LSB +: 4]));

        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end

        // CTRL write without start, new operand and opposite op
        if (num_cases > 0) begin
            apb_write(`FPCONV_ADDR_OPLO, 32'h1234_5678);
            ctrl = 32'd0;
            ctrl[`FPCONV_CTRL_OP] = ~case_mem[num_cases-1][132];
            apb_write(`FPCONV_ADDR_CTRL, ctrl);
            read_reg(`FPCONV_ADDR_STATUS, status);
            check_done(1'b1, status[`FPCONV_STATUS_DONE]);
            check_flags(fpconv_pkg::fp_flags_t'(case_mem[num_cases-1][3:0]),
                        fpconv_pkg::fp_flags_t'(status[`FPCONV_STATUS_FLAGS_LSB +: 4]));
            read_reg(`FPCONV_ADDR_RESLO, res_lo);
            read_reg(`FPCONV_ADDR_RESHI, res_hi);
            check_result("result", case_mem[num_cases-1][67:4], {res_hi, res_lo});
        end

        // Unmapped offset
        apb_read(8'h18, rdata, slverr);
        check_slverr(1'b1, slverr);
        check_result("prdata", 64'd0, {32'd0, rdata});

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
